//--- list.f
common/div_pkg.sv
common/div_core_if.sv
divider/radix2_divider.sv
divider/divider_unit.sv
src/div_top.sv
test/divider_props.sv
test/div_top_tb.sv

//--- run.sh
#!/bin/sh
# Builds the divide unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f list.f --top-module div_top_tb

status=0
out=$(./obj_dir/Vdiv_top_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Test passed"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

//--- test/div_top_tb.sv
// Testbench for the RV32 integer divide unit
// Drives directed corner cases and seeded random operations, checks each
// result against a RISC-V arithmetic model, and checks the stall length
`default_nettype none

module div_top_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import div_pkg::*;

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 5;
	localparam int NUM_RANDOM    = 400;
	localparam int NUM_DIRECTED  = 6;
	// Issue, 8 iterations, done cycle, DONE cycle and one idle cycle in WAIT
	localparam int CYCLES_PER_OP = 12;
	localparam int RUN_CYCLES    = 10;
	localparam int MAX_RUN       = 20;
	localparam int TIMEOUT_NS    = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_OP * CLK_PERIOD
		+ RESET_CYCLES * CLK_PERIOD + 1000;

	localparam logic [XLEN-1:0] MOST_NEG  = {1'b1, {(XLEN-1){1'b0}}};
	localparam logic [XLEN-1:0] MINUS_ONE = '1;

	logic            CLK;
	logic            nrst;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic            div_valid;
	div_op_e         div_op;
	logic            div_running;
	logic [XLEN-1:0] div_out;

	integer seed;
	int     errors;

	div_top UUT (
		.CLK         (CLK),
		.nrst        (nrst),
		.op_a        (op_a),
		.op_b        (op_b),
		.div_valid   (div_valid),
		.div_op      (div_op),
		.div_running (div_running),
		.div_out     (div_out)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// RISC-V results with divide by zero and signed overflow handled before the arithmetic
	function automatic logic [XLEN-1:0] model_div(input div_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic                   overflow;
		logic signed [XLEN-1:0] signed_q;
		logic signed [XLEN-1:0] signed_r;
		logic [XLEN-1:0]        unsigned_q;
		logic [XLEN-1:0]        unsigned_r;
		logic [XLEN-1:0]        res;

		overflow   = (a == MOST_NEG) && (b == MINUS_ONE);
		signed_q   = '0;
		signed_r   = '0;
		unsigned_q = '0;
		unsigned_r = '0;
		if (b != '0) begin
			unsigned_q = a / b;
			unsigned_r = a % b;
			if (!overflow) begin
				signed_q = $signed(a) / $signed(b);
				signed_r = $signed(a) % $signed(b);
			end
		end
		case (op)
			DIV:     res = (b == '0) ? '1 : (overflow ? MOST_NEG : signed_q);
			DIVU:    res = (b == '0) ? '1 : unsigned_q;
			REM:     res = (b == '0) ? a : (overflow ? '0 : signed_r);
			default: res = (b == '0) ? a : unsigned_r;
		endcase
		return res;
	endfunction

	task automatic abort_run();
		errors++;
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
			abort_run();
		end
	endtask

	// One clock with junk on every input including div_valid
	task automatic busy_cycle();
		@(negedge CLK);
		op_a      = $random(seed);
		op_b      = $random(seed);
		div_op    = div_op_e'(2'($random(seed)));
		div_valid = 1'($random(seed));
		#1;
	endtask

	// Issues one operation in WAIT and follows it through DONE and one idle cycle
	task automatic run_op(input div_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0] expected;
		int              run_cycles;

		expected = model_div(op, a, b);
		@(negedge CLK);
		op_a      = a;
		op_b      = b;
		div_op    = op;
		div_valid = 1'b1;
		#1;
		// The stall level must rise already in the issue cycle
		check_value("div_running", XLEN'(div_running), XLEN'(1'b1));
		run_cycles = 1;
		busy_cycle();
		while (div_running) begin
			run_cycles++;
			assert (run_cycles <= MAX_RUN) else begin
				$display("div_running did not fall within %0d cycles", MAX_RUN);
				abort_run();
			end
			busy_cycle();
		end
		// First cycle with the stall low is DONE, and the result is already registered
		check_value("div_running cycles", XLEN'(run_cycles), XLEN'(RUN_CYCLES));
		check_value("div_out", div_out, expected);
		// A div_valid in DONE must not have started anything
		@(negedge CLK);
		div_valid = 1'b0;
		#1;
		check_value("div_running", XLEN'(div_running), XLEN'(1'b0));
		check_value("div_out", div_out, expected);
	endtask

	// Divisors lean towards zero, one and minus one, dividends towards the most negative value
	task automatic random_operands(output logic [XLEN-1:0] a, output logic [XLEN-1:0] b,
		output div_op_e op);
		int pick;

		pick = $unsigned($random(seed)) % 15;
		case (pick)
			0:       b = '0;
			1:       b = 32'd1;
			2:       b = MINUS_ONE;
			3, 4, 5: b = $random(seed) & 32'h0000_00FF;
			default: b = $random(seed);
		endcase
		pick = $unsigned($random(seed)) % 8;
		a  = (pick == 0) ? MOST_NEG : $random(seed);
		op = div_op_e'(2'($random(seed)));
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the operations did not complete", TIMEOUT_NS);
		abort_run();
	end

	initial begin
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		div_op_e         op;

		seed      = 60;
		errors    = 0;
		nrst      = 1'b0;
		op_a      = '0;
		op_b      = '0;
		div_valid = 1'b0;
		div_op    = DIV;
		repeat (RESET_CYCLES) @(negedge CLK);
		nrst = 1'b1;
		#1;
		check_value("div_running", XLEN'(div_running), XLEN'(1'b0));
		check_value("div_out", div_out, '0);

		// Divide by zero and signed overflow are also compared with the literal results
		run_op(DIV, 32'h1234_5678, '0);
		check_value("div_out", div_out, 32'hFFFF_FFFF);
		run_op(DIVU, 32'h8765_4321, '0);
		check_value("div_out", div_out, 32'hFFFF_FFFF);
		run_op(REM, 32'hDEAD_BEEF, '0);
		check_value("div_out", div_out, 32'hDEAD_BEEF);
		run_op(REMU, 32'h0BAD_F00D, '0);
		check_value("div_out", div_out, 32'h0BAD_F00D);
		run_op(DIV, MOST_NEG, MINUS_ONE);
		check_value("div_out", div_out, 32'h8000_0000);
		run_op(REM, MOST_NEG, MINUS_ONE);
		check_value("div_out", div_out, 32'h0000_0000);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			random_operands(a, b, op);
			run_op(op, a, b);
		end

		if (errors == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- test/divider_props.sv
// Stall and state properties of the divide control unit
// Bound into divider_unit, watching the FSM state, the core start and done
`default_nettype none

module divider_props (
	input logic                   CLK,
	input logic                   nrst,
	input div_pkg::div_state_e    div_state,
	input logic                   start,
	input logic                   done,
	input logic                   div_running
);
	timeunit 1ns;
	timeprecision 1ps;
	import div_pkg::*;

	// A new operation reaches the core only after the stall of the previous one has ended
	start_after_idle: assert property (@(posedge CLK) disable iff (!nrst)
		start |-> !$past(div_running))
		else $error("Core start without an idle cycle before it");

	// The FSM leaves WAIT at once, so start can never last two cycles
	start_single: assert property (@(posedge CLK) disable iff (!nrst)
		start |=> !start)
		else $error("Core start held for more than one cycle");

	// 8 iteration clocks after the capture edge, then the done cycle
	done_after_start: assert property (@(posedge CLK) disable iff (!nrst)
		start |-> ##9 done)
		else $error("Core done missing 9 cycles after start");

	// Together with the check above this pins done to exactly 9 cycles
	done_from_start: assert property (@(posedge CLK) disable iff (!nrst)
		done |-> $past(start, 9))
		else $error("Core done without a start 9 cycles earlier");

	// The stall covers issue, iterations and the done cycle, and drops in DONE
	stall_ends_in_done: assert property (@(posedge CLK) disable iff (!nrst)
		$fell(div_running) |-> (div_state == DONE) && $past(start, 10))
		else $error("div_running did not fall into DONE 10 cycles after start");

endmodule

bind divider_unit divider_props u_props (
	.CLK         (CLK),
	.nrst        (nrst),
	.div_state   (div_state),
	.start       (issue),
	.done        (core.done),
	.div_running (div_running)
);

`default_nettype wire

//--- src/div_top.sv
// Top level of the RV32 integer divide unit
// Joins the control unit and the iterative core over the core link
`default_nettype none

module div_top (
	input  logic                      CLK,
	input  logic                      nrst,
	input  logic [div_pkg::XLEN-1:0]  op_a,
	input  logic [div_pkg::XLEN-1:0]  op_b,
	input  logic                      div_valid,
	input  div_pkg::div_op_e          div_op,
	output logic                      div_running,
	output logic [div_pkg::XLEN-1:0]  div_out
);

	// Operand and result link between control and core
	div_core_if core_bus ();

	// FSM, sign handling and output register
	divider_unit u_ctrl (
		.CLK         (CLK),
		.nrst        (nrst),
		.op_a        (op_a),
		.op_b        (op_b),
		.div_valid   (div_valid),
		.div_op      (div_op),
		.div_running (div_running),
		.div_out     (div_out),
		.core        (core_bus.ctrl)
	);

	// Unsigned four bits per clock divider
	radix2_divider u_core (
		.CLK  (CLK),
		.nrst (nrst),
		.core (core_bus.core)
	);

endmodule

`default_nettype wire

//--- divider/divider_unit.sv
// Integer divide control unit for DIV, DIVU, REM and REMU
// Runs the stall FSM, feeds operand magnitudes to the iterative core,
// and restores signs and divide-by-zero results into the output register
`default_nettype none

module divider_unit (
	input  logic                      CLK,
	input  logic                      nrst,
	input  logic [div_pkg::XLEN-1:0]  op_a,
	input  logic [div_pkg::XLEN-1:0]  op_b,
	input  logic                      div_valid,
	input  div_pkg::div_op_e          div_op,
	output logic                      div_running,
	output logic [div_pkg::XLEN-1:0]  div_out,
	div_core_if.ctrl                  core
);
	import div_pkg::*;

	div_state_e div_state;
	div_state_e div_nstate;

	// Issue happens only while idle, div_valid is ignored in every other state
	logic issue;

	// Sign handling of the incoming operands
	logic signed_op;
	logic a_neg;
	logic b_neg;

	// Captured at issue so the inputs are free to change while dividing
	div_op_e         op_q;
	logic            q_neg_q;
	logic            r_neg_q;
	logic            div_zero_q;
	logic [XLEN-1:0] op_a_q;

	// Result path from the core
	logic            want_quot;
	logic [XLEN-1:0] raw_sel;
	logic [XLEN-1:0] signed_sel;
	logic [XLEN-1:0] result;

	assign issue = (div_state == WAIT) && div_valid;

	// Only DIV and REM treat the operands as two's complement
	assign signed_op = (div_op == DIV) || (div_op == REM);
	assign a_neg     = signed_op && op_a[XLEN-1];
	assign b_neg     = signed_op && op_b[XLEN-1];

	// The core works on magnitudes, so negative signed operands are negated here
	// Negating the most negative value leaves it unchanged, which is the right magnitude
	assign core.start    = issue;
	assign core.dividend = a_neg ? -op_a : op_a;
	assign core.divisor  = b_neg ? -op_b : op_b;

	// State register
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			div_state <= RESET;
		end else begin
			div_state <= div_nstate;
		end
	end

	// RESET idles one cycle, DONE always drops back to WAIT
	always_comb begin
		div_nstate = div_state;
		unique case (div_state)
			RESET:    div_nstate = WAIT;
			WAIT:     div_nstate = div_valid ? DIVIDING : WAIT;
			DIVIDING: div_nstate = core.done ? DONE : DIVIDING;
			DONE:     div_nstate = WAIT;
			default:  div_nstate = RESET;
		endcase
	end

	// Stall level for the pipeline
	// It rises in the issue cycle already so the instruction is held in EXE
	always_comb begin
		unique case (div_state)
			RESET:    div_running = 1'b0;
			WAIT:     div_running = div_valid;
			DIVIDING: div_running = 1'b1;
			DONE:     div_running = 1'b0;
			default:  div_running = 1'b0;
		endcase
	end

	// Opcode, sign flags and zero flag are sampled in the issue cycle
	always_ff @(posedge CLK) begin
		if (issue) begin
			op_q       <= div_op;
			q_neg_q    <= a_neg ^ b_neg;
			r_neg_q    <= a_neg;
			div_zero_q <= (op_b == '0);
			op_a_q     <= op_a;
		end
	end

	// Pick the quotient for DIV and DIVU, the remainder otherwise
	assign want_quot = (op_q == DIV) || (op_q == DIVU);
	assign raw_sel   = want_quot ? core.quotient : core.remainder;

	// Quotient sign is the XOR of the operand signs, remainder takes the dividend sign
	// The flags are clear for unsigned opcodes, so those pass through untouched
	always_comb begin
		if (want_quot ? q_neg_q : r_neg_q) begin
			signed_sel = -raw_sel;
		end else begin
			signed_sel = raw_sel;
		end
	end

	// RISC-V divide by zero gives all ones for the quotient and the dividend as remainder
	// Without this override a negative signed dividend would yield +1 as quotient
	always_comb begin
		if (div_zero_q) begin
			result = want_quot ? '1 : op_a_q;
		end else begin
			result = signed_sel;
		end
	end

	// Loaded on the done edge, so the value is ready in the DONE cycle
	// It then holds until the next operation completes
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			div_out <= '0;
		end else if ((div_state == DIVIDING) && core.done) begin
			div_out <= result;
		end
	end

endmodule

`default_nettype wire

//--- divider/radix2_divider.sv
// Unsigned iterative restoring divider
// Retires BITS_PER_CYCLE quotient bits per clock through chained subtract stages
// Quotient bits shift into the dividend register as the dividend bits leave it
`default_nettype none

module radix2_divider (
	input  logic     CLK,
	input  logic     nrst,
	div_core_if.core core
);
	import div_pkg::*;

	// Control state of the iteration
	logic                 busy;
	logic [DIV_CNT_W-1:0] step_cnt;
	logic                 last_step;
	logic                 iterating;

	// Partial remainder, shifting dividend and captured divisor
	logic [XLEN-1:0] part_rem;
	logic [XLEN-1:0] dvd_shift;
	logic [XLEN-1:0] divisor_q;

	// Values after the combinational stages of one clock
	logic [XLEN-1:0] next_rem;
	logic [XLEN-1:0] next_shift;

	// After DIV_STEPS iterations the counter parks here for the done cycle
	assign last_step = (step_cnt == DIV_CNT_W'(DIV_STEPS));
	assign iterating = busy && !last_step;

	// Restoring steps, one per quotient bit
	// The trial value needs XLEN+1 bits because the remainder is shifted before the subtract
	always_comb begin : restoring_steps
		logic [XLEN:0]   trial;
		logic [XLEN:0]   diff;
		logic [XLEN-1:0] rem_v;
		logic [XLEN-1:0] shift_v;

		rem_v   = part_rem;
		shift_v = dvd_shift;
		for (int i = 0; i < BITS_PER_CYCLE; i++) begin
			trial = {rem_v, shift_v[XLEN-1]};
			diff  = trial - {1'b0, divisor_q};
			// A clear sign bit means the divisor fit, so the quotient bit is one
			shift_v = {shift_v[XLEN-2:0], ~diff[XLEN]};
			rem_v   = diff[XLEN] ? trial[XLEN-1:0] : diff[XLEN-1:0];
		end
		next_rem   = rem_v;
		next_shift = shift_v;
	end

	// Start loads the counter, the iteration then runs for DIV_STEPS clocks
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			busy     <= 1'b0;
			step_cnt <= '0;
		end else if (core.start) begin
			busy     <= 1'b1;
			step_cnt <= '0;
		end else if (iterating) begin
			step_cnt <= step_cnt + 1'b1;
		end else if (busy) begin
			// Done cycle ends here
			busy <= 1'b0;
		end
	end

	// Datapath, frozen once the last step is taken so the result holds
	// With a zero divisor every trial fits, giving all ones and the dividend as remainder
	always_ff @(posedge CLK) begin
		if (core.start) begin
			part_rem  <= '0;
			dvd_shift <= core.dividend;
			divisor_q <= core.divisor;
		end else if (iterating) begin
			part_rem  <= next_rem;
			dvd_shift <= next_shift;
		end
	end

	// Done is high for the single cycle in which the counter sits at DIV_STEPS
	assign core.done      = busy && last_step;
	assign core.quotient  = dvd_shift;
	assign core.remainder = part_rem;

endmodule

`default_nettype wire

//--- common/div_core_if.sv
// Link between the divide control unit and the iterative core
// Operands are magnitudes, valid in the start cycle and captured at its edge
// Done pulses once per start, with quotient and remainder held afterwards
`default_nettype none

interface div_core_if;
	import div_pkg::*;

	// One-cycle request from the control unit
	logic            start;
	logic [XLEN-1:0] dividend;
	logic [XLEN-1:0] divisor;

	// Unsigned results, valid from the done cycle onwards
	logic [XLEN-1:0] quotient;
	logic [XLEN-1:0] remainder;
	logic            done;

	// Control side issues operands and collects the result
	modport ctrl (
		output start, dividend, divisor,
		input  quotient, remainder, done
	);

	// Core side computes on the captured magnitudes
	modport core (
		input  start, dividend, divisor,
		output quotient, remainder, done
	);

endinterface

`default_nettype wire

//--- common/div_pkg.sv
// Divide unit package
// Holds the operand width, the iteration constants of the radix-2 core
// and the opcode and FSM state encodings shared by the divide unit
`default_nettype none

package div_pkg;

	// Operand and result width of the RV32 datapath
	localparam int XLEN = 32;

	// Quotient bits retired by the core on every clock
	localparam int BITS_PER_CYCLE = 4;

	// Clocks needed to retire a full quotient
	localparam int DIV_STEPS = XLEN / BITS_PER_CYCLE;

	// The step counter has to reach DIV_STEPS itself, which marks the done cycle
	localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

	// Encoded as the pipeline decoder sends them
	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_e;

	// Control states of the divide unit
	typedef enum logic [1:0] {
		RESET    = 2'd0,
		WAIT     = 2'd1,
		DIVIDING = 2'd2,
		DONE     = 2'd3
	} div_state_e;

endpackage

`default_nettype wire
